// File: include/crossbar_macros.svh
`ifndef CROSSBAR_MACROS_SVH
`define CROSSBAR_MACROS_SVH

// Payload and address widths
`define DATA_WIDTH 16
`define ADDR_WIDTH 6

// Port counts, GPU plus spines
`define NUM_SPINES 4
`define NUM_PORTS 5

// GPU address field that picks the spine
`define ROUTE_MSB 5
`define ROUTE_LSB 2

`endif

// File: source/crossbar_pkg.sv
`include "crossbar_macros.svh"

package crossbar_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    // Grant encoding, also the round-robin pointer
    typedef enum logic [2:0] {
        PORT_NONE   = 3'd0,
        PORT_GPU    = 3'd1,
        PORT_SPINE1 = 3'd2,
        PORT_SPINE2 = 3'd3,
        PORT_SPINE3 = 3'd4,
        PORT_SPINE4 = 3'd5
    } port_id_t;

    typedef enum logic [1:0] {
        IDLE         = 2'd0,
        GPU_TO_SPINE = 2'd1,
        SPINE_TO_GPU = 2'd2
    } xbar_state_t;

endpackage

// File: source/port_request_capture.sv
`timescale 1ns/1ns
`include "crossbar_macros.svh"

module port_request_capture import crossbar_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  data_t                         gpu_incoming_data,
    input  logic                          gpu_incoming_valid,
    input  logic                          gpu_ready,
    input  logic [`ADDR_WIDTH-1:0]        gpu_dest_addr,
    input  data_t [`NUM_SPINES-1:0]       spine_out_data,
    input  logic  [`NUM_SPINES-1:0]       spine_out_valid,
    input  logic  [`NUM_SPINES-1:0]       spine_ready,
    input  logic  [`NUM_PORTS-1:0]        pending_clear,
    output logic  [`NUM_PORTS-1:0]        pending,
    output data_t [`NUM_PORTS-1:0]        pending_data,
    output logic  [`ADDR_WIDTH-1:0]       pending_addr
);

    logic  [`NUM_PORTS-1:0] valid_vec;
    logic  [`NUM_PORTS-1:0] ready_vec;
    logic  [`NUM_PORTS-1:0] valid_d;
    logic  [`NUM_PORTS-1:0] request;
    data_t [`NUM_PORTS-1:0] data_vec;

    // Bit 0 is the GPU, bits 1 to 4 the spines
    assign valid_vec = {spine_out_valid, gpu_incoming_valid};
    assign ready_vec = {spine_ready, gpu_ready};
    assign data_vec  = {spine_out_data, gpu_incoming_data};

    // Rising valid, qualified by ready
    assign request = valid_vec & ~valid_d & ready_vec;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d <= '0;
            pending <= '0;
        end else begin
            valid_d <= valid_vec;
            // New request wins over a clear
            pending <= (pending & ~pending_clear) | request;
        end
    end

    // Latest request overwrites the latched payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `NUM_PORTS; i++) begin
            if (request[i]) begin
                pending_data[i] <= data_vec[i];
            end
        end
        if (request[0]) begin
            pending_addr <= gpu_dest_addr;
        end
    end

    // ====================
    // Checks
    // ====================
    a_no_spurious_pending: assert property (
        @(posedge clk) disable iff (reset)
        (pending & ~$past(pending) & ~$past(request)) == '0
    );

endmodule

// File: source/transfer_arbiter.sv
`timescale 1ns/1ns
`include "crossbar_macros.svh"

module transfer_arbiter import crossbar_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          arb_enable,
    input  logic  [`NUM_PORTS-1:0]        pending,
    input  data_t [`NUM_PORTS-1:0]        pending_data,
    input  logic  [`ADDR_WIDTH-1:0]       pending_addr,
    output logic  [`NUM_PORTS-1:0]        pending_clear,
    output xbar_state_t                   state,
    output logic  [1:0]                   target_spine,
    output data_t                         transfer_data,
    output port_id_t                      current_grant
);

    port_id_t   rr_ptr;
    logic [2:0] start_idx;
    logic [2:0] winner_idx;
    logic       grant;
    logic [1:0] route_spine;
    logic [`ROUTE_MSB-`ROUTE_LSB:0] route_field;

    // First pending port at or after start, wrapping over all ports
    function automatic logic [2:0] search_from(
        input logic [`NUM_PORTS-1:0] req,
        input logic [2:0]            start
    );
        int         idx;
        logic [2:0] result;
        logic       found;
        result = 3'd0;
        found  = 1'b0;
        for (int k = 0; k < `NUM_PORTS; k++) begin
            idx = int'(start) + k;
            if (idx >= `NUM_PORTS) begin
                idx = idx - `NUM_PORTS;
            end
            if (!found && req[idx]) begin
                result = 3'(idx);
                found  = 1'b1;
            end
        end
        return result;
    endfunction

    // ====================
    // Winner selection
    // ====================
    // Fixed priority is a search starting at the GPU
    assign start_idx  = arb_enable ? 3'(rr_ptr - 3'd1) : 3'd0;
    assign winner_idx = search_from(pending, start_idx);
    assign grant      = (state == IDLE) && (|pending);

    always_comb begin
        pending_clear = '0;
        if (grant) begin
            pending_clear[winner_idx] = 1'b1;
        end
    end

    // Out-of-range field values fall back to spine 1
    assign route_field = pending_addr[`ROUTE_MSB:`ROUTE_LSB];

    always_comb begin
        case (route_field)
            4'd2:    route_spine = 2'd1;
            4'd3:    route_spine = 2'd2;
            4'd4:    route_spine = 2'd3;
            default: route_spine = 2'd0;
        endcase
    end

    // ====================
    // State and grant
    // ====================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= IDLE;
            current_grant <= PORT_NONE;
            target_spine  <= 2'd0;
            rr_ptr        <= PORT_GPU;
        end else begin
            case (state)
                IDLE: begin
                    if (grant) begin
                        current_grant <= port_id_t'(winner_idx + 3'd1);
                        target_spine  <= route_spine;
                        state <= (winner_idx == 3'd0) ? GPU_TO_SPINE : SPINE_TO_GPU;
                    end
                end
                default: begin
                    state <= IDLE;
                    if (arb_enable) begin
                        rr_ptr <= (rr_ptr == PORT_SPINE4) ? PORT_GPU : port_id_t'(rr_ptr + 3'd1);
                    end
                end
            endcase
        end
    end

    // Payload of the granted port
    always_ff @(posedge clk) begin
        if (grant) begin
            transfer_data <= pending_data[winner_idx];
        end
    end

    // ====================
    // Checks
    // ====================
    a_single_cycle_transfer: assert property (
        @(posedge clk) disable iff (reset)
        (state != IDLE) |=> (state == IDLE)
    );

    a_clear_onehot: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(pending_clear)
    );

endmodule

// File: source/port_output_driver.sv
`timescale 1ns/1ns
`include "crossbar_macros.svh"

module port_output_driver import crossbar_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  xbar_state_t                   state,
    input  logic  [1:0]                   target_spine,
    input  data_t                         transfer_data,
    output data_t                         gpu_outgoing_data,
    output logic                          gpu_outgoing_valid,
    output data_t [`NUM_SPINES-1:0]       spine_in_data,
    output logic  [`NUM_SPINES-1:0]       spine_in_valid
);

    logic to_gpu;
    logic to_spine;

    assign to_gpu   = (state == SPINE_TO_GPU);
    assign to_spine = (state == GPU_TO_SPINE);

    // One-cycle valid pulses
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            gpu_outgoing_valid <= 1'b0;
            spine_in_valid     <= '0;
        end else begin
            gpu_outgoing_valid <= to_gpu;
            spine_in_valid     <= '0;
            if (to_spine) begin
                spine_in_valid[target_spine] <= 1'b1;
            end
        end
    end

    // Data holds until that port is written again
    always_ff @(posedge clk) begin
        if (to_gpu) begin
            gpu_outgoing_data <= transfer_data;
        end
        if (to_spine) begin
            spine_in_data[target_spine] <= transfer_data;
        end
    end

    // ====================
    // Checks
    // ====================
    a_one_output_valid: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({gpu_outgoing_valid, spine_in_valid})
    );

endmodule

// File: source/spine_crossbar.sv
`timescale 1ns/1ns
`include "crossbar_macros.svh"

module spine_crossbar import crossbar_pkg::*; (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          arb_enable,

    // GPU port
    input  data_t                         gpu_incoming_data,
    input  logic                          gpu_incoming_valid,
    input  logic                          gpu_ready,
    input  logic  [`ADDR_WIDTH-1:0]       gpu_dest_addr,
    output data_t                         gpu_outgoing_data,
    output logic                          gpu_outgoing_valid,

    // Spines 1 to 4 on bits 0 to 3
    input  data_t [`NUM_SPINES-1:0]       spine_out_data,
    input  logic  [`NUM_SPINES-1:0]       spine_out_valid,
    input  logic  [`NUM_SPINES-1:0]       spine_ready,
    output data_t [`NUM_SPINES-1:0]       spine_in_data,
    output logic  [`NUM_SPINES-1:0]       spine_in_valid,

    output logic                          busy,
    output port_id_t                      current_grant
);

    logic  [`NUM_PORTS-1:0]  pending;
    data_t [`NUM_PORTS-1:0]  pending_data;
    logic  [`ADDR_WIDTH-1:0] pending_addr;
    logic  [`NUM_PORTS-1:0]  pending_clear;
    xbar_state_t             state;
    logic  [1:0]             target_spine;
    data_t                   transfer_data;

    assign busy = (state != IDLE);

    port_request_capture capture_i (
        .clk                (clk),
        .reset              (reset),
        .gpu_incoming_data  (gpu_incoming_data),
        .gpu_incoming_valid (gpu_incoming_valid),
        .gpu_ready          (gpu_ready),
        .gpu_dest_addr      (gpu_dest_addr),
        .spine_out_data     (spine_out_data),
        .spine_out_valid    (spine_out_valid),
        .spine_ready        (spine_ready),
        .pending_clear      (pending_clear),
        .pending            (pending),
        .pending_data       (pending_data),
        .pending_addr       (pending_addr)
    );

    transfer_arbiter arbiter_i (
        .clk           (clk),
        .reset         (reset),
        .arb_enable    (arb_enable),
        .pending       (pending),
        .pending_data  (pending_data),
        .pending_addr  (pending_addr),
        .pending_clear (pending_clear),
        .state         (state),
        .target_spine  (target_spine),
        .transfer_data (transfer_data),
        .current_grant (current_grant)
    );

    port_output_driver driver_i (
        .clk                (clk),
        .reset              (reset),
        .state              (state),
        .target_spine       (target_spine),
        .transfer_data      (transfer_data),
        .gpu_outgoing_data  (gpu_outgoing_data),
        .gpu_outgoing_valid (gpu_outgoing_valid),
        .spine_in_data      (spine_in_data),
        .spine_in_valid     (spine_in_valid)
    );

endmodule

// File: verification/spine_crossbar_tb.sv
`timescale 1ns/1ns
`include "crossbar_macros.svh"

module spine_crossbar_tb import crossbar_pkg::*; ();

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT  = 40;

    logic                    clk;
    logic                    reset;
    logic                    arb_enable;
    data_t                   gpu_incoming_data;
    logic                    gpu_incoming_valid;
    logic                    gpu_ready;
    logic [`ADDR_WIDTH-1:0]  gpu_dest_addr;
    data_t                   gpu_outgoing_data;
    logic                    gpu_outgoing_valid;
    data_t [`NUM_SPINES-1:0] spine_out_data;
    logic  [`NUM_SPINES-1:0] spine_out_valid;
    logic  [`NUM_SPINES-1:0] spine_ready;
    data_t [`NUM_SPINES-1:0] spine_in_data;
    logic  [`NUM_SPINES-1:0] spine_in_valid;
    logic                    busy;
    port_id_t                current_grant;

    integer seed = 32'hf638_f562;
    int     errors = 0;
    int     pulses = 0;
    int     e_pulses = 0;

    // Reference model state, index 0 is the GPU
    logic  [`NUM_PORTS-1:0]  m_valid_d;
    logic  [`NUM_PORTS-1:0]  m_pending;
    data_t [`NUM_PORTS-1:0]  m_data;
    logic  [`ADDR_WIDTH-1:0] m_addr;
    logic                    m_busy;
    logic  [2:0]             m_grant;
    int                      m_ptr;
    data_t                   m_xfer;
    logic  [1:0]             m_target;
    logic                    e_gpu_valid;
    data_t                   e_gpu_data;
    logic  [`NUM_SPINES-1:0] e_spine_valid;
    data_t [`NUM_SPINES-1:0] e_spine_data;

    spine_crossbar dut_i (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2);
            clk = ~clk;
        end
    end

    // First requesting port at or after the start port
    function automatic int pick_winner(input logic [`NUM_PORTS-1:0] req, input int ptr,
                                       input logic rr);
        int first;
        int idx;
        pick_winner = 0;
        first = rr ? ptr - 1 : 0;
        for (int k = `NUM_PORTS - 1; k >= 0; k--) begin
            idx = (first + k) % `NUM_PORTS;
            if (req[idx]) begin
                pick_winner = idx;
            end
        end
    endfunction

    function automatic logic [1:0] route_target(input logic [`ADDR_WIDTH-1:0] addr);
        logic [3:0] field;
        field = addr[`ROUTE_MSB:`ROUTE_LSB];
        if (field >= 4'd1 && field <= 4'd4) begin
            return 2'(field - 4'd1);
        end
        return 2'd0;
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] got,
                                            input logic [31:0] exp);
        errors++;
        $display("[ERROR] %s: got %h, expected %h", name, got, exp);
    endfunction

    // ====================
    // Reference model
    // ====================
    always @(posedge clk or posedge reset) begin : reference_model
        logic  [`NUM_PORTS-1:0] req;
        data_t [`NUM_PORTS-1:0] words;
        int                     w;
        if (reset) begin
            m_valid_d = '0;
            m_pending = '0;
            m_busy = 1'b0;
            m_grant = 3'd0;
            m_ptr = 1;
            e_gpu_valid = 1'b0;
            e_spine_valid = '0;
        end else begin
            req = {spine_out_valid, gpu_incoming_valid} & ~m_valid_d & {spine_ready, gpu_ready};
            words = {spine_out_data, gpu_incoming_data};
            e_gpu_valid = 1'b0;
            e_spine_valid = '0;
            if (m_busy) begin
                if (m_grant == 3'd1) begin
                    e_spine_valid[m_target] = 1'b1;
                    e_spine_data[m_target] = m_xfer;
                end else begin
                    e_gpu_valid = 1'b1;
                    e_gpu_data = m_xfer;
                end
                e_pulses++;
                m_busy = 1'b0;
                if (arb_enable) begin
                    m_ptr = (m_ptr == `NUM_PORTS) ? 1 : m_ptr + 1;
                end
            end else if (m_pending != '0) begin
                w = pick_winner(m_pending, m_ptr, arb_enable);
                m_pending[w] = 1'b0;
                m_grant = 3'(w + 1);
                m_xfer = m_data[w];
                m_target = route_target(m_addr);
                m_busy = 1'b1;
            end
            // Requests land after the grant so a fresh one survives the clear
            for (int i = 0; i < `NUM_PORTS; i++) begin
                if (req[i]) begin
                    m_pending[i] = 1'b1;
                    m_data[i] = words[i];
                end
            end
            if (req[0]) begin
                m_addr = gpu_dest_addr;
            end
            m_valid_d = {spine_out_valid, gpu_incoming_valid};
        end
    end

    always @(posedge clk) begin
        if (!reset && (gpu_outgoing_valid || spine_in_valid != '0)) begin
            pulses <= pulses + 1;
        end
    end

    // ====================
    // Checks
    // ====================
    a_gpu_valid: assert property (@(posedge clk) disable iff (reset)
        gpu_outgoing_valid == e_gpu_valid)
    else report_mismatch("gpu_outgoing_valid", 32'($sampled(gpu_outgoing_valid)),
                         32'($sampled(e_gpu_valid)));

    a_gpu_data: assert property (@(posedge clk) disable iff (reset)
        gpu_outgoing_valid |-> gpu_outgoing_data == e_gpu_data)
    else report_mismatch("gpu_outgoing_data", 32'($sampled(gpu_outgoing_data)),
                         32'($sampled(e_gpu_data)));

    a_spine_valid: assert property (@(posedge clk) disable iff (reset)
        spine_in_valid == e_spine_valid)
    else report_mismatch("spine_in_valid", 32'($sampled(spine_in_valid)),
                         32'($sampled(e_spine_valid)));

    for (genvar s = 0; s < `NUM_SPINES; s++) begin : g_spine_data
        a_spine_data: assert property (@(posedge clk) disable iff (reset)
            spine_in_valid[s] |-> spine_in_data[s] == e_spine_data[s])
        else report_mismatch($sformatf("spine_in_data[%0d]", s),
                             32'($sampled(spine_in_data[s])), 32'($sampled(e_spine_data[s])));
    end

    a_busy: assert property (@(posedge clk) disable iff (reset) busy == m_busy)
    else report_mismatch("busy", 32'($sampled(busy)), 32'($sampled(m_busy)));

    a_grant: assert property (@(posedge clk) disable iff (reset) current_grant == m_grant)
    else report_mismatch("current_grant", 32'($sampled(current_grant)), 32'($sampled(m_grant)));

    // ====================
    // Stimulus
    // ====================
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation failed");
        $fatal(1, "Run stopped on a timeout");
    endtask

    task automatic wait_output(input string what);
        int cycles;
        cycles = 0;
        while (!gpu_outgoing_valid && spine_in_valid == '0 && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (!gpu_outgoing_valid && spine_in_valid == '0) begin
            abort_run(what);
        end
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while ((m_pending != '0 || m_busy || busy) && cycles < WAIT_LIMIT) begin
            step();
            cycles++;
        end
        if (m_pending != '0 || m_busy || busy) begin
            abort_run(what);
        end
        // Last output pulse
        step();
    endtask

    task automatic send_gpu(input logic [3:0] field);
        gpu_incoming_data  = data_t'($random(seed));
        gpu_dest_addr      = {field, 2'($random(seed))};
        gpu_incoming_valid = 1'b1;
        step();
        gpu_incoming_valid = 1'b0;
        wait_output("a spine pulse from a GPU request");
        step();
    endtask

    task automatic send_spine(input int s);
        spine_out_data[s]  = data_t'($random(seed));
        spine_out_valid[s] = 1'b1;
        step();
        spine_out_valid[s] = 1'b0;
        wait_output("a GPU pulse from a spine request");
        step();
    endtask

    // Bit 0 GPU, bits 1 to 4 spines
    task automatic burst(input logic [`NUM_PORTS-1:0] mask);
        gpu_incoming_data = data_t'($random(seed));
        gpu_dest_addr     = `ADDR_WIDTH'($random(seed));
        for (int s = 0; s < `NUM_SPINES; s++) begin
            spine_out_data[s] = data_t'($random(seed));
        end
        gpu_incoming_valid = mask[0];
        spine_out_valid    = mask[`NUM_PORTS-1:1];
        step();
        gpu_incoming_valid = 1'b0;
        spine_out_valid    = '0;
        wait_drained("a request burst to drain");
    endtask

    initial begin
        reset = 1'b1;
        arb_enable = 1'b0;
        gpu_incoming_data = '0;
        gpu_incoming_valid = 1'b0;
        gpu_ready = 1'b1;
        gpu_dest_addr = '0;
        spine_out_data = '0;
        spine_out_valid = '0;
        spine_ready = '1;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        repeat (4) step();

        // Address fields 1 to 4, then 0
        for (int f = 1; f <= 5; f++) begin
            send_gpu(4'(f % 5));
        end
        for (int s = 0; s < `NUM_SPINES; s++) begin
            send_spine(s);
        end

        // Held valid gives one pulse
        gpu_incoming_data = data_t'($random(seed));
        gpu_incoming_valid = 1'b1;
        step();
        wait_output("the pulse from a held GPU valid");
        repeat (8) step();
        gpu_incoming_valid = 1'b0;

        // Valid rises while ready is low, so no request
        spine_ready[2] = 1'b0;
        spine_out_data[2] = data_t'($random(seed));
        spine_out_valid[2] = 1'b1;
        repeat (2) step();
        spine_ready[2] = 1'b1;
        repeat (4) step();
        spine_out_valid[2] = 1'b0;
        wait_drained("the crossbar to stay idle");

        burst(5'b11111);

        arb_enable = 1'b1;
        burst(5'b11111);
        burst(5'b10110);
        burst(5'b11111);
        burst(5'b01011);
        burst(5'b11111);
        arb_enable = 1'b0;
        step();

        if (pulses != e_pulses) begin
            errors++;
            $display("Number of output pulses differs from the reference model");
        end
        $display("Errors: %0d, output pulses: %0d, expected pulses: %0d",
                 errors, pulses, e_pulses);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: spine_crossbar.f
+incdir+include
source/crossbar_pkg.sv
source/port_request_capture.sv
source/transfer_arbiter.sv
source/port_output_driver.sv
source/spine_crossbar.sv
verification/spine_crossbar_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= spine_crossbar_tb
FILELIST  ?= spine_crossbar.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || (echo "Run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
